// File: verilog/rvv_alu_pkg.sv
// rvv_alu_pkg
// Shared constants of the vector integer ALU execute stage: widths,
// queue and reorder-buffer depths, opcodes, and the second-operand
// word that a unit reads either as a lane vector or as a scalar.

`default_nettype none

package rvv_alu_pkg;

  // cluster and operand geometry
  localparam int NUM_ALU   = 2;
  localparam int VLEN      = 32;
  localparam int EEW       = 8;
  localparam int LANES     = VLEN / EEW;

  // queue depths
  localparam int RS_DEPTH  = 4;
  localparam int ROB_DEPTH = 8;

  // derived widths
  localparam int TAG_W     = $clog2(ROB_DEPTH);
  localparam int OP_W      = 3;
  localparam int RS_PTR_W  = $clog2(RS_DEPTH);
  localparam int RS_CNT_W  = $clog2(RS_DEPTH + 1);
  localparam int ROB_CNT_W = $clog2(ROB_DEPTH + 1);
  localparam int ALU_IDX_W = (NUM_ALU > 1) ? $clog2(NUM_ALU) : 1;

  // opcodes
  localparam logic [OP_W-1:0] OP_ADD  = 3'd0;
  localparam logic [OP_W-1:0] OP_SUB  = 3'd1;
  localparam logic [OP_W-1:0] OP_AND  = 3'd2;
  localparam logic [OP_W-1:0] OP_OR   = 3'd3;
  localparam logic [OP_W-1:0] OP_XOR  = 3'd4;
  localparam logic [OP_W-1:0] OP_MINU = 3'd5;
  localparam logic [OP_W-1:0] OP_MAXU = 3'd6;
  // shift amount is the low 3 bits of the src2 element
  localparam logic [OP_W-1:0] OP_SLL  = 3'd7;

  // second operand, selected per micro-op by use_scalar
  //   vec    one element per lane
  //   scalar low EEW bits broadcast to every lane
  typedef union packed {
    logic [LANES-1:0][EEW-1:0] vec;
    logic [VLEN-1:0]           scalar;
  } alu_src2_u;

endpackage

`default_nettype wire

// File: verilog/alu_rs_fifo.sv
// alu_rs_fifo
// Reservation-station queue for vector ALU micro-ops. Stamps each
// accepted micro-op with the next reorder tag, shows its oldest
// entries as issue slots and drops a run of them on pop.

`default_nettype none

module alu_rs_fifo (
  input  logic                                                 clk,
  input  logic                                                 rst,
  input  logic                                                 in_valid,
  input  logic [rvv_alu_pkg::OP_W-1:0]                         in_op,
  input  logic [rvv_alu_pkg::VLEN-1:0]                         in_vs1,
  input  rvv_alu_pkg::alu_src2_u                               in_src2,
  input  logic                                                 in_use_scalar,
  input  logic [rvv_alu_pkg::NUM_ALU-1:0]                      pop,
  input  logic                                                 retire,
  output logic                                                 in_ready,
  output logic [rvv_alu_pkg::NUM_ALU-1:0]                      slot_valid,
  output logic [rvv_alu_pkg::NUM_ALU-1:0][rvv_alu_pkg::OP_W-1:0] slot_op,
  output logic [rvv_alu_pkg::NUM_ALU-1:0][rvv_alu_pkg::VLEN-1:0] slot_vs1,
  output rvv_alu_pkg::alu_src2_u [rvv_alu_pkg::NUM_ALU-1:0]    slot_src2,
  output logic [rvv_alu_pkg::NUM_ALU-1:0]                      slot_use_scalar,
  output logic [rvv_alu_pkg::NUM_ALU-1:0][rvv_alu_pkg::TAG_W-1:0] slot_tag
);

  import rvv_alu_pkg::*;

  // entry storage
  logic [OP_W-1:0]      op_q     [RS_DEPTH];
  logic [VLEN-1:0]      vs1_q    [RS_DEPTH];
  alu_src2_u            src2_q   [RS_DEPTH];
  logic                 scalar_q [RS_DEPTH];
  logic [TAG_W-1:0]     tag_q    [RS_DEPTH];

  logic [RS_PTR_W-1:0]  rd_ptr;
  logic [RS_PTR_W-1:0]  wr_ptr;
  logic [RS_CNT_W-1:0]  count;
  logic [RS_CNT_W-1:0]  pop_num;
  logic [TAG_W-1:0]     next_tag;
  logic [ROB_CNT_W-1:0] outstanding;
  logic                 push;

  // full queue or every ROB tag in use blocks issue
  assign in_ready = (count != RS_CNT_W'(RS_DEPTH)) &&
                    (outstanding != ROB_CNT_W'(ROB_DEPTH));
  assign push     = in_valid & in_ready;

  // pop is a run from bit 0, so a popcount gives the entries to drop
  always_comb begin
    pop_num = '0;
    for (int i = 0; i < NUM_ALU; i++) begin
      pop_num = pop_num + RS_CNT_W'(pop[i]);
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      op_q[wr_ptr]     <= in_op;
      vs1_q[wr_ptr]    <= in_vs1;
      src2_q[wr_ptr]   <= in_src2;
      scalar_q[wr_ptr] <= in_use_scalar;
      tag_q[wr_ptr]    <= next_tag;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_ptr      <= '0;
      wr_ptr      <= '0;
      count       <= '0;
      next_tag    <= '0;
      outstanding <= '0;
    end else begin
      if (push) begin
        wr_ptr   <= wr_ptr + 1'b1;
        next_tag <= next_tag + 1'b1;
      end
      rd_ptr      <= rd_ptr + RS_PTR_W'(pop_num);
      count       <= count + RS_CNT_W'(push) - pop_num;
      // tags stay in use until the ROB commits them
      outstanding <= outstanding + ROB_CNT_W'(push) - ROB_CNT_W'(retire);
    end
  end

  // slot i is the entry i places behind the read pointer
  for (genvar i = 0; i < NUM_ALU; i++) begin : g_slot
    logic [RS_PTR_W-1:0] idx;

    assign idx                = rd_ptr + RS_PTR_W'(i);
    assign slot_valid[i]      = count > RS_CNT_W'(i);
    assign slot_op[i]         = op_q[idx];
    assign slot_vs1[i]        = vs1_q[idx];
    assign slot_src2[i]       = src2_q[idx];
    assign slot_use_scalar[i] = scalar_q[idx];
    assign slot_tag[i]        = tag_q[idx];
  end

endmodule

`default_nettype wire

// File: verilog/alu_unit.sv
// alu_unit
// One vector ALU unit. Applies the micro-op to every 8-bit lane and
// keeps the result with its reorder tag in a register until the
// ROB takes it.

`default_nettype none

module alu_unit (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            uop_valid,
  input  logic [rvv_alu_pkg::OP_W-1:0]    uop_op,
  input  logic [rvv_alu_pkg::VLEN-1:0]    uop_vs1,
  input  rvv_alu_pkg::alu_src2_u          uop_src2,
  input  logic                            uop_use_scalar,
  input  logic [rvv_alu_pkg::TAG_W-1:0]   uop_tag,
  input  logic                            take,
  input  logic                            res_ready,
  output logic                            can_accept,
  output logic                            res_valid,
  output logic [rvv_alu_pkg::TAG_W-1:0]   res_tag,
  output logic [rvv_alu_pkg::VLEN-1:0]    res_data
);

  import rvv_alu_pkg::*;

  logic [LANES-1:0][EEW-1:0] lane_res;
  logic                      drain;

  // per-lane datapath
  for (genvar l = 0; l < LANES; l++) begin : g_lane
    logic [EEW-1:0] a;
    logic [EEW-1:0] b;

    assign a = uop_vs1[l*EEW +: EEW];
    // scalar form broadcasts the low element of the scalar word
    assign b = uop_use_scalar ? uop_src2.scalar[EEW-1:0] : uop_src2.vec[l];

    always_comb begin
      case (uop_op)
        OP_ADD:  lane_res[l] = a + b;
        OP_SUB:  lane_res[l] = a - b;
        OP_AND:  lane_res[l] = a & b;
        OP_OR:   lane_res[l] = a | b;
        OP_XOR:  lane_res[l] = a ^ b;
        OP_MINU: lane_res[l] = (a < b) ? a : b;
        OP_MAXU: lane_res[l] = (a > b) ? a : b;
        OP_SLL:  lane_res[l] = a << b[2:0];
        default: lane_res[l] = '0;
      endcase
    end
  end

  assign drain = res_valid & res_ready;

  // free now, or emptied by the ROB on this edge
  assign can_accept = uop_valid & (~res_valid | res_ready);

  always_ff @(posedge clk) begin
    if (rst) begin
      res_valid <= 1'b0;
    end else if (take) begin
      res_valid <= 1'b1;
    end else if (drain) begin
      res_valid <= 1'b0;
    end
  end

  // result payload
  always_ff @(posedge clk) begin
    if (take) begin
      res_data <= lane_res;
      res_tag  <= uop_tag;
    end
  end

endmodule

`default_nettype wire

// File: verilog/alu_cluster.sv
// alu_cluster
// Cluster of NUM_ALU vector ALU units. Unit i works on issue slot i;
// the pop mask only covers a run of ready units from slot 0, so
// micro-ops leave the reservation station in order.

`default_nettype none

module alu_cluster (
  input  logic                                                   clk,
  input  logic                                                   rst,
  input  logic [rvv_alu_pkg::NUM_ALU-1:0]                        slot_valid,
  input  logic [rvv_alu_pkg::NUM_ALU-1:0][rvv_alu_pkg::OP_W-1:0] slot_op,
  input  logic [rvv_alu_pkg::NUM_ALU-1:0][rvv_alu_pkg::VLEN-1:0] slot_vs1,
  input  rvv_alu_pkg::alu_src2_u [rvv_alu_pkg::NUM_ALU-1:0]      slot_src2,
  input  logic [rvv_alu_pkg::NUM_ALU-1:0]                        slot_use_scalar,
  input  logic [rvv_alu_pkg::NUM_ALU-1:0][rvv_alu_pkg::TAG_W-1:0] slot_tag,
  input  logic [rvv_alu_pkg::NUM_ALU-1:0]                        res_ready,
  output logic [rvv_alu_pkg::NUM_ALU-1:0]                        pop,
  output logic [rvv_alu_pkg::NUM_ALU-1:0]                        res_valid,
  output logic [rvv_alu_pkg::NUM_ALU-1:0][rvv_alu_pkg::TAG_W-1:0] res_tag,
  output logic [rvv_alu_pkg::NUM_ALU-1:0][rvv_alu_pkg::VLEN-1:0] res_data
);

  import rvv_alu_pkg::*;

  logic [NUM_ALU-1:0] can_accept;

  // a slot pops only when every lower slot pops too
  always_comb begin
    pop[0] = can_accept[0];
    for (int i = 1; i < NUM_ALU; i++) begin
      pop[i] = pop[i-1] & can_accept[i];
    end
  end

  for (genvar i = 0; i < NUM_ALU; i++) begin : g_unit
    alu_unit u_alu_unit (
      .clk            (clk),
      .rst            (rst),
      .uop_valid      (slot_valid[i]),
      .uop_op         (slot_op[i]),
      .uop_vs1        (slot_vs1[i]),
      .uop_src2       (slot_src2[i]),
      .uop_use_scalar (slot_use_scalar[i]),
      .uop_tag        (slot_tag[i]),
      .take           (pop[i]),
      .res_ready      (res_ready[i]),
      .can_accept     (can_accept[i]),
      .res_valid      (res_valid[i]),
      .res_tag        (res_tag[i]),
      .res_data       (res_data[i])
    );
  end

endmodule

`default_nettype wire

// File: verilog/rob_writeback.sv
// rob_writeback
// Reorder buffer for the ALU cluster. Takes one unit result per cycle
// by round robin, files it under its tag and commits finished entries
// in tag order, pulsing retire for each commit.

`default_nettype none

module rob_writeback (
  input  logic                                                    clk,
  input  logic                                                    rst,
  input  logic [rvv_alu_pkg::NUM_ALU-1:0]                         res_valid,
  input  logic [rvv_alu_pkg::NUM_ALU-1:0][rvv_alu_pkg::TAG_W-1:0] res_tag,
  input  logic [rvv_alu_pkg::NUM_ALU-1:0][rvv_alu_pkg::VLEN-1:0]  res_data,
  input  logic                                                    out_ready,
  output logic [rvv_alu_pkg::NUM_ALU-1:0]                         res_ready,
  output logic                                                    out_valid,
  output logic [rvv_alu_pkg::TAG_W-1:0]                           out_tag,
  output logic [rvv_alu_pkg::VLEN-1:0]                            out_data,
  output logic                                                    retire
);

  import rvv_alu_pkg::*;

  logic [VLEN-1:0]      data_q [ROB_DEPTH];
  logic [ROB_DEPTH-1:0] done;
  logic [TAG_W-1:0]     head;
  logic [ALU_IDX_W-1:0] rr_ptr;
  logic [ALU_IDX_W-1:0] win_idx;
  logic [NUM_ALU-1:0]   grant;
  logic                 write_en;
  logic                 commit;

  // round robin, searching upward from rr_ptr
  always_comb begin : rr_arb
    int unsigned cand;
    grant   = '0;
    win_idx = '0;
    for (int k = 0; k < NUM_ALU; k++) begin
      cand = (int'(rr_ptr) + k) % NUM_ALU;
      if (grant == '0 && res_valid[cand]) begin
        grant[cand] = 1'b1;
        win_idx     = ALU_IDX_W'(cand);
      end
    end
  end

  assign res_ready = grant;
  assign write_en  = |grant;

  // head of the buffer drives the commit port
  assign out_valid = done[head];
  assign out_tag   = head;
  assign out_data  = data_q[head];
  assign commit    = out_valid & out_ready;
  assign retire    = commit;

  always_ff @(posedge clk) begin
    if (write_en) begin
      data_q[res_tag[win_idx]] <= res_data[win_idx];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      done   <= '0;
      head   <= '0;
      rr_ptr <= '0;
    end else begin
      if (commit) begin
        done[head] <= 1'b0;
        head       <= head + 1'b1;
      end
      // a live tag never equals the head being cleared
      if (write_en) begin
        done[res_tag[win_idx]] <= 1'b1;
        if (win_idx == ALU_IDX_W'(NUM_ALU - 1)) begin
          rr_ptr <= '0;
        end else begin
          rr_ptr <= win_idx + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/rvv_alu_top.sv
// rvv_alu_top
// Integer ALU execute stage of the vector backend: reservation
// station, ALU cluster and reorder buffer.

`default_nettype none

module rvv_alu_top (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            in_valid,
  input  logic [rvv_alu_pkg::OP_W-1:0]    in_op,
  input  logic [rvv_alu_pkg::VLEN-1:0]    in_vs1,
  input  rvv_alu_pkg::alu_src2_u          in_src2,
  input  logic                            in_use_scalar,
  input  logic                            out_ready,
  output logic                            in_ready,
  output logic                            out_valid,
  output logic [rvv_alu_pkg::TAG_W-1:0]   out_tag,
  output logic [rvv_alu_pkg::VLEN-1:0]    out_data
);

  import rvv_alu_pkg::*;

  // queue to cluster
  logic [NUM_ALU-1:0]            slot_valid;
  logic [NUM_ALU-1:0][OP_W-1:0]  slot_op;
  logic [NUM_ALU-1:0][VLEN-1:0]  slot_vs1;
  alu_src2_u [NUM_ALU-1:0]       slot_src2;
  logic [NUM_ALU-1:0]            slot_use_scalar;
  logic [NUM_ALU-1:0][TAG_W-1:0] slot_tag;
  logic [NUM_ALU-1:0]            pop;

  // cluster to ROB
  logic [NUM_ALU-1:0]            res_valid;
  logic [NUM_ALU-1:0]            res_ready;
  logic [NUM_ALU-1:0][TAG_W-1:0] res_tag;
  logic [NUM_ALU-1:0][VLEN-1:0]  res_data;
  logic                          retire;

  alu_rs_fifo u_rs_fifo (
    .clk             (clk),
    .rst             (rst),
    .in_valid        (in_valid),
    .in_op           (in_op),
    .in_vs1          (in_vs1),
    .in_src2         (in_src2),
    .in_use_scalar   (in_use_scalar),
    .pop             (pop),
    .retire          (retire),
    .in_ready        (in_ready),
    .slot_valid      (slot_valid),
    .slot_op         (slot_op),
    .slot_vs1        (slot_vs1),
    .slot_src2       (slot_src2),
    .slot_use_scalar (slot_use_scalar),
    .slot_tag        (slot_tag)
  );

  alu_cluster u_cluster (
    .clk             (clk),
    .rst             (rst),
    .slot_valid      (slot_valid),
    .slot_op         (slot_op),
    .slot_vs1        (slot_vs1),
    .slot_src2       (slot_src2),
    .slot_use_scalar (slot_use_scalar),
    .slot_tag        (slot_tag),
    .res_ready       (res_ready),
    .pop             (pop),
    .res_valid       (res_valid),
    .res_tag         (res_tag),
    .res_data        (res_data)
  );

  rob_writeback u_rob (
    .clk       (clk),
    .rst       (rst),
    .res_valid (res_valid),
    .res_tag   (res_tag),
    .res_data  (res_data),
    .out_ready (out_ready),
    .res_ready (res_ready),
    .out_valid (out_valid),
    .out_tag   (out_tag),
    .out_data  (out_data),
    .retire    (retire)
  );

endmodule

`default_nettype wire

// File: bench/tb_rvv_alu.sv
// tb_rvv_alu
// Random-stimulus testbench for the vector ALU execute stage. A queue
// model predicts every committed result and tag in issue order and
// checks reset state, scalar broadcast and ROB back-pressure.

`default_nettype none

module tb_rvv_alu;

  import rvv_alu_pkg::*;

  localparam int CLK_PERIOD      = 10;
  localparam int DRIVE_DELAY     = 1;
  localparam int PER_OP_CYCLES   = 20;
  localparam int SCALAR_CYCLES   = 80;
  localparam int DENSE_CYCLES    = 300;
  localparam int HOLD_CYCLES     = 30;
  localparam int IDLE_CYCLES     = 4;
  localparam int TOTAL_CYCLES    = 8 * PER_OP_CYCLES + SCALAR_CYCLES + DENSE_CYCLES + HOLD_CYCLES;
  localparam int WATCHDOG_CYCLES = 20 * TOTAL_CYCLES + 200;

  logic              clk = 1'b0;
  logic              rst;
  logic              in_valid;
  logic [OP_W-1:0]   in_op;
  logic [VLEN-1:0]   in_vs1;
  logic [VLEN-1:0]   in_src2;
  logic              in_use_scalar;
  logic              out_ready;
  logic              in_ready;
  logic              out_valid;
  logic [TAG_W-1:0]  out_tag;
  logic [VLEN-1:0]   out_data;

  // model state
  logic [31:0]       rng_state = 32'ha070_cae3;
  logic [VLEN-1:0]   exp_data [$];
  logic [TAG_W-1:0]  exp_tag [$];
  int                accept_count = 0;
  int                commit_count = 0;
  logic              pending = 1'b0;
  logic              held = 1'b0;
  logic [VLEN-1:0]   held_data;
  logic [TAG_W-1:0]  held_tag;

  rvv_alu_top i_dut (
    .clk           (clk),
    .rst           (rst),
    .in_valid      (in_valid),
    .in_op         (in_op),
    .in_vs1        (in_vs1),
    .in_src2       (in_src2),
    .in_use_scalar (in_use_scalar),
    .out_ready     (out_ready),
    .in_ready      (in_ready),
    .out_valid     (out_valid),
    .out_tag       (out_tag),
    .out_data      (out_data)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // one element of the expected result
  function automatic logic [EEW-1:0] model_lane(input logic [OP_W-1:0] op,
                                                input logic [EEW-1:0] a,
                                                input logic [EEW-1:0] b);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      OP_MINU: return (a < b) ? a : b;
      OP_MAXU: return (a > b) ? a : b;
      default: return a << b[2:0];
    endcase
  endfunction

  function automatic logic [VLEN-1:0] model_result(input logic [OP_W-1:0] op,
                                                   input logic [VLEN-1:0] vs1,
                                                   input logic [VLEN-1:0] src2,
                                                   input logic use_scalar);
    logic [VLEN-1:0] r;
    logic [EEW-1:0]  b;
    r = '0;
    for (int l = 0; l < LANES; l++) begin
      // scalar form only looks at the low element of the word
      b = use_scalar ? src2[EEW-1:0] : src2[l*EEW +: EEW];
      r[l*EEW +: EEW] = model_lane(op, vs1[l*EEW +: EEW], b);
    end
    return r;
  endfunction

  task automatic fail_plain(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("FAIL %s expected %h actual %h", name, expected, actual);
      $display("Errors found");
      $fatal(1, "simulation stopped");
    end
  endtask

  // look at both handshakes in mid-cycle, where all inputs have settled
  task automatic observe();
    if (held) begin
      check_value("hold_valid", 32'd1, 32'(out_valid));
      check_value("hold_data", held_data, out_data);
      check_value("hold_tag", 32'(held_tag), 32'(out_tag));
    end
    held      = out_valid && !out_ready;
    held_data = out_data;
    held_tag  = out_tag;
    if (in_valid && in_ready) begin
      exp_data.push_back(model_result(in_op, in_vs1, in_src2, in_use_scalar));
      exp_tag.push_back(TAG_W'(accept_count));
      accept_count++;
      pending = 1'b0;
    end
    if (out_valid && out_ready) begin
      if (exp_data.size() == 0) begin
        fail_plain("a result was committed with no micro-op outstanding");
      end else begin
        if (commit_count == 0) begin
          check_value("first_commit_tag", 32'd0, 32'(out_tag));
        end
        check_value("commit_tag", 32'(exp_tag[0]), 32'(out_tag));
        check_value("commit_data", exp_data[0], out_data);
        void'(exp_data.pop_front());
        void'(exp_tag.pop_front());
        commit_count++;
      end
    end
    if (exp_data.size() > ROB_DEPTH) begin
      fail_plain("more micro-ops were accepted than the ROB can hold");
    end
  endtask

  // op_sel 0..7 fixes the opcode, 8 picks one at random
  // scalar_sel 0 vector, 1 scalar, 2 random
  task automatic step(input int valid_pct, input int ready_pct, input int op_sel,
                      input int scalar_sel);
    logic [31:0] r;
    @(posedge clk);
    #(DRIVE_DELAY);
    if (!pending && (next_rand() % 100) < valid_pct) begin
      r = next_rand();
      in_op   = (op_sel < 8) ? OP_W'(op_sel) : r[OP_W-1:0];
      in_vs1  = next_rand();
      in_src2 = next_rand();
      if (scalar_sel == 2) begin
        in_use_scalar = r[8];
      end else begin
        in_use_scalar = (scalar_sel == 1);
      end
      pending = 1'b1;
    end
    in_valid  = pending;
    out_ready = (next_rand() % 100) < ready_pct;
    @(negedge clk);
    observe();
  endtask

  initial begin
    rst           = 1'b1;
    in_valid      = 1'b0;
    in_op         = '0;
    in_vs1        = '0;
    in_src2       = '0;
    in_use_scalar = 1'b0;
    out_ready     = 1'b0;
    repeat (2) @(posedge clk);
    #(DRIVE_DELAY);
    rst = 1'b0;
    @(negedge clk);
    check_value("reset_out_valid", 32'd0, 32'(out_valid));
    check_value("reset_in_ready", 32'd1, 32'(in_ready));

    // every opcode in vector form
    for (int op = 0; op < 8; op++) begin
      repeat (PER_OP_CYCLES) step(90, 100, op, 0);
    end
    // scalar broadcast with random upper bits
    repeat (SCALAR_CYCLES) step(90, 100, 8, 1);
    // dense issue against random consumer stalls
    repeat (DENSE_CYCLES) step(100, 60, 8, 2);
    // consumer stalled, issue keeps pushing
    repeat (HOLD_CYCLES) step(100, 0, 8, 2);
    check_value("backpressure_fill", 32'(ROB_DEPTH), 32'(exp_data.size()));
    // drain everything still in flight
    while (pending || exp_data.size() != 0) begin
      step(0, 100, 8, 2);
    end
    // idle a few cycles so a duplicated result would still show up
    repeat (IDLE_CYCLES) step(0, 100, 8, 2);
    check_value("drained_out_valid", 32'd0, 32'(out_valid));
    check_value("drained_in_ready", 32'd1, 32'(in_ready));

    $display("No errors");
    $finish;
  end

  initial begin
    #(CLK_PERIOD * WATCHDOG_CYCLES);
    fail_plain("timeout: the run did not finish in the expected number of cycles");
  end

endmodule

`default_nettype wire

// File: build.f
verilog/rvv_alu_pkg.sv
verilog/alu_rs_fifo.sv
verilog/alu_unit.sv
verilog/alu_cluster.sv
verilog/rob_writeback.sv
verilog/rvv_alu_top.sv
bench/tb_rvv_alu.sv

// File: run_sim.sh
#!/bin/sh
# build and run the ALU execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_rvv_alu -f build.f -o sim_rvv_alu

result=$(./obj_dir/sim_rvv_alu 2>&1 || true)
echo "$result"

# pass only if the testbench printed its pass line
echo "$result" | grep -qx "No errors"
